//--- Bender.yml
package:
  name: mem_subsys

sources:
  - rtl/mem_pkg.sv
  - rtl/qspi_ctrl.sv
  - rtl/mem_arbiter.sv
  - rtl/mem_subsys_top.sv
  - target: test
    files:
      - dv/qspi_mem_model.sv
      - dv/tb_mem_subsys.sv

//--- dv/qspi_mem_model.sv
// Quad-SPI flash and RAM model
`default_nettype none

module qspi_mem_model #(
    parameter int DUMMY_CYCLES = 6
) (
    input  mem_pkg::spi_out_t spi_out,
    output logic [3:0]        spi_in
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    logic [7:0]  flash_mem [0:65535];
    logic [7:0]  ram_a_mem [0:65535];
    logic [7:0]  ram_b_mem [0:65535];

    int          edge_cnt;
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [3:0]  hi_nib;
    logic        idle;

    assign idle = spi_out.flash_sel_n && spi_out.ram_a_sel_n && spi_out.ram_b_sel_n;

    initial begin
        spi_in   = 4'h0;
        edge_cnt = 0;
    end

    // A new transaction starts with the next select
    always @(posedge idle) begin
        edge_cnt = 0;
    end

    function automatic logic [7:0] read_byte(input logic [15:0] idx);
        if (!spi_out.ram_a_sel_n) begin
            return ram_a_mem[idx];
        end else if (!spi_out.ram_b_sel_n) begin
            return ram_b_mem[idx];
        end
        return flash_mem[idx];
    endfunction

    // Flash ignores writes
    task automatic write_byte(input logic [15:0] idx, input logic [7:0] val);
        if (!spi_out.ram_a_sel_n) begin
            ram_a_mem[idx] = val;
        end else if (!spi_out.ram_b_sel_n) begin
            ram_b_mem[idx] = val;
        end
    endtask

    // Host nibbles are sampled on the rising SPI edge
    always @(posedge spi_out.sclk) begin
        int         k;
        logic [15:0] idx;
        logic [7:0]  rb;
        logic [3:0]  nib;
        // Pins the host does not drive read as unknown
        nib = (spi_out.oe == 4'hf) ? spi_out.dout : 4'hx;
        if (!idle) begin
            if (edge_cnt < 2) begin
                cmd = {cmd[3:0], nib};
            end else if (edge_cnt < 8) begin
                addr = {addr[19:0], nib};
            end else if (cmd == CMD_QWRITE) begin
                k   = edge_cnt - 8;
                idx = addr[15:0] + 16'(k / 2);
                if (!k[0]) begin
                    hi_nib = nib;
                end else begin
                    write_byte(idx, {hi_nib, nib});
                end
            end else if (edge_cnt >= 8 + DUMMY_CYCLES) begin
                // Nibble stays on the pins until the next rising edge
                k   = edge_cnt - 8 - DUMMY_CYCLES;
                idx = addr[15:0] + 16'(k / 2);
                rb  = read_byte(idx);
                // Contention with a host that still drives gives an unknown nibble
                if (spi_out.oe == 4'h0) begin
                    spi_in <= k[0] ? rb[3:0] : rb[7:4];
                end else begin
                    spi_in <= 4'hx;
                end
            end
            edge_cnt++;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_subsys.sv
// Memory subsystem testbench
`default_nettype none

module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    localparam int DUMMY_CYCLES = 6;
    localparam int WAIT_LIMIT   = 2000;

    logic        clk = 1'b0;
    logic        rstn;
    logic [23:1] instr_addr;
    logic        instr_fetch_restart;
    logic        instr_fetch_stall;
    logic        instr_fetch_started;
    logic        instr_fetch_stopped;
    logic [15:0] instr_data;
    logic        instr_ready;
    data_req_t   data_req;
    logic        data_ready;
    logic [31:0] data_from_read;
    logic [3:0]  spi_in;
    spi_out_t    spi_out;

    // Expected memory contents
    logic [7:0]  flash_ref [0:65535];
    logic [7:0]  ram_a_ref [0:65535];
    logic [7:0]  ram_b_ref [0:65535];

    logic [31:0] exp_data;
    logic [23:1] fetch_base;
    logic [23:1] fetch_ptr;
    int          instr_count   = 0;
    int          data_count    = 0;
    int          started_count = 0;
    int          stopped_count = 0;

    always #50 clk = ~clk;

    mem_subsys_top #(
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) i_mem_subsys_top (
        .clk                 (clk),
        .rstn                (rstn),
        .instr_addr          (instr_addr),
        .instr_fetch_restart (instr_fetch_restart),
        .instr_fetch_stall   (instr_fetch_stall),
        .instr_fetch_started (instr_fetch_started),
        .instr_fetch_stopped (instr_fetch_stopped),
        .instr_data          (instr_data),
        .instr_ready         (instr_ready),
        .data_req            (data_req),
        .data_ready          (data_ready),
        .data_from_read      (data_from_read),
        .spi_in              (spi_in),
        .spi_out             (spi_out)
    );

    qspi_mem_model #(
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) i_qspi_mem_model (
        .spi_out (spi_out),
        .spi_in  (spi_in)
    );

    // Galois LFSR with bit 0 as the output bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Expected read value zero-extended above the access size
    function automatic logic [31:0] ref_read(input logic [24:0] addr, input txn_size_e size);
        int          n;
        logic [15:0] idx;
        logic [31:0] r;
        n = (size == SIZE_8) ? 1 : (size == SIZE_16) ? 2 : 4;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            idx = addr[15:0] + 16'(i);
            case (addr[24:23])
                2'b10:   r[8*i +: 8] = ram_a_ref[idx];
                2'b11:   r[8*i +: 8] = ram_b_ref[idx];
                default: r[8*i +: 8] = flash_ref[idx];
            endcase
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
                              input data_req_t req);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] data_from_read addr %h: got %h, expected %h",
                                     req.addr, got, exp));
        end
    endtask

    task automatic check_instr(input logic [15:0] got, input logic [15:0] exp,
                               input logic [23:1] hw);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] instr_data halfword %h: got %h, expected %h",
                                     hw, got, exp));
        end
    endtask

    // Compare process sampling at the rising edge
    always @(posedge clk) begin
        if (rstn) begin
            if (instr_fetch_started) begin
                fetch_ptr = fetch_base;
                started_count++;
            end
            if (instr_fetch_stopped) begin
                stopped_count++;
            end
            if (instr_ready) begin
                check_instr(instr_data, ref_read({1'b0, fetch_ptr, 1'b0}, SIZE_16), fetch_ptr);
                fetch_ptr = fetch_ptr + 23'd1;
                instr_count++;
            end
            if (data_ready) begin
                if (data_req.read_n != SIZE_NONE) begin
                    check_data(data_from_read, exp_data, data_req);
                end
                data_count++;
            end
        end
    end

    task automatic write_shadow(input logic [24:0] addr, input logic [7:0] val);
        case (addr[24:23])
            2'b10:   ram_a_ref[addr[15:0]] = val;
            2'b11:   ram_b_ref[addr[15:0]] = val;
            default: ;
        endcase
    endtask

    task automatic drive_access(input logic [24:0] addr, input txn_size_e wr,
                                input txn_size_e rd, input logic [31:0] wdata);
        int target;
        int cycles;
        @(negedge clk);
        if (rd != SIZE_NONE) begin
            exp_data = ref_read(addr, rd);
        end
        target           = data_count + 1;
        data_req.addr    = addr;
        data_req.write_n = wr;
        data_req.read_n  = rd;
        data_req.wdata   = wdata;
        cycles = 0;
        while (data_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure($sformatf("Timeout waiting for data_ready at %h", addr));
            end
        end
        data_req.write_n = SIZE_NONE;
        data_req.read_n  = SIZE_NONE;
        if (wr != SIZE_NONE) begin
            for (int i = 0; i < ((wr == SIZE_8) ? 1 : (wr == SIZE_16) ? 2 : 4); i++) begin
                write_shadow(addr + 25'(i), wdata[8*i +: 8]);
            end
        end
    endtask

    task automatic restart_fetch(input logic [23:1] hw);
        int target;
        int cycles;
        target = started_count + 1;
        @(negedge clk);
        instr_addr          = hw;
        fetch_base          = hw;
        instr_fetch_restart = 1'b1;
        @(negedge clk);
        instr_fetch_restart = 1'b0;
        cycles = 0;
        while (started_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("Fetch restart never produced instr_fetch_started");
            end
        end
    endtask

    task automatic wait_instr(input int n);
        int target;
        int cycles;
        target = instr_count + n;
        cycles = 0;
        while (instr_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("Timeout waiting for instr_ready");
            end
        end
    endtask

    initial begin
        logic [15:0] lfsr;
        logic [7:0]  b;
        logic [15:0] a;
        int          seen;
        rstn                = 1'b0;
        instr_addr          = '0;
        instr_fetch_restart = 1'b0;
        instr_fetch_stall   = 1'b0;
        data_req.addr       = '0;
        data_req.write_n    = SIZE_NONE;
        data_req.read_n     = SIZE_NONE;
        data_req.wdata      = '0;
        fetch_base          = '0;
        fetch_ptr           = '0;

        // Flash from the LFSR and RAMs from an address pattern
        lfsr = 16'd38;
        for (int i = 0; i < 65536; i++) begin
            a = 16'(i);
            b = 8'h0;
            for (int j = 0; j < 8; j++) begin
                b    = {b[6:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
            flash_ref[i] = b;
            ram_a_ref[i] = a[7:0] ^ a[15:8] ^ 8'h5a;
            ram_b_ref[i] = a[7:0] ^ {a[14:8], a[15]} ^ 8'hc3;
            i_qspi_mem_model.flash_mem[i] = flash_ref[i];
            i_qspi_mem_model.ram_a_mem[i] = ram_a_ref[i];
            i_qspi_mem_model.ram_b_mem[i] = ram_b_ref[i];
        end

        repeat (5) @(negedge clk);
        rstn = 1'b1;

        // Word write and read on both RAMs
        drive_access(25'h100_0100, SIZE_32, SIZE_NONE, 32'h1234_a5c3);
        drive_access(25'h100_0100, SIZE_NONE, SIZE_32, 32'h0);
        drive_access(25'h180_0100, SIZE_32, SIZE_NONE, 32'h89ab_0f71);
        drive_access(25'h180_0100, SIZE_NONE, SIZE_32, 32'h0);
        drive_access(25'h100_0100, SIZE_NONE, SIZE_32, 32'h0);

        // Narrow accesses at odd offsets
        drive_access(25'h100_0200, SIZE_32, SIZE_NONE, 32'h7766_5544);
        drive_access(25'h100_0201, SIZE_8, SIZE_NONE, 32'hffff_ff9e);
        drive_access(25'h100_0203, SIZE_16, SIZE_NONE, 32'hffff_3cd2);
        drive_access(25'h100_0201, SIZE_NONE, SIZE_8, 32'h0);
        drive_access(25'h100_0203, SIZE_NONE, SIZE_16, 32'h0);
        drive_access(25'h100_0200, SIZE_NONE, SIZE_32, 32'h0);
        drive_access(25'h100_0204, SIZE_NONE, SIZE_32, 32'h0);
        drive_access(25'h180_0377, SIZE_16, SIZE_NONE, 32'h0000_e815);
        drive_access(25'h180_0377, SIZE_NONE, SIZE_16, 32'h0);
        drive_access(25'h000_1235, SIZE_NONE, SIZE_8, 32'h0);
        drive_access(25'h000_2a07, SIZE_NONE, SIZE_16, 32'h0);

        // Fetch stream from flash
        restart_fetch(23'h000400);
        wait_instr(4);

        // Stall holds back the next halfword
        instr_fetch_stall = 1'b1;
        seen = instr_count;
        repeat (60) @(negedge clk);
        if (instr_count != seen) begin
            report_failure("instr_ready arrived while the fetch was stalled");
        end
        instr_fetch_stall = 1'b0;
        wait_instr(2);

        // Restart to a new address mid-stream
        seen = stopped_count;
        restart_fetch(23'h002a11);
        if (stopped_count != seen + 1) begin
            report_failure("Mid-stream restart gave no instr_fetch_stopped");
        end
        wait_instr(4);

        // Data read cuts into a running fetch
        restart_fetch(23'h001234);
        wait_instr(2);
        seen = stopped_count;
        drive_access(25'h000_3001, SIZE_NONE, SIZE_32, 32'h0);
        if (stopped_count != seen + 1) begin
            report_failure("Data read during fetch gave no instr_fetch_stopped");
        end
        seen = instr_count;
        repeat (100) @(negedge clk);
        if (instr_count != seen) begin
            report_failure("Fetch delivered halfwords after being stopped");
        end

        $display("All tests passed!");
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 200000) begin
            @(posedge clk);
            cycles++;
        end
        $display("Simulation ran out of time");
        $display("Test failures found");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
// Fetch and data arbiter
`default_nettype none

module mem_arbiter (
    input  logic               clk,
    input  logic               rstn,

    input  logic [23:1]        instr_addr,
    input  logic               instr_fetch_restart,
    input  logic               instr_fetch_stall,
    output logic               instr_fetch_started,
    output logic               instr_fetch_stopped,
    output logic [15:0]        instr_data,
    output logic               instr_ready,

    input  mem_pkg::data_req_t data_req,
    output logic               data_ready,
    output logic [31:0]        data_from_read,

    output logic [24:0]        q_addr,
    output logic [7:0]         q_wdata,
    output logic               q_start_read,
    output logic               q_start_write,
    output logic               q_stall,
    output logic               q_stop,
    input  logic [7:0]         q_rdata,
    input  logic               q_data_req,
    input  logic               q_data_ready,
    input  logic               q_busy
);
    import mem_pkg::*;

    logic [1:0]  data_txn_n;
    logic [1:0]  data_len;
    logic        data_pending;
    logic        fetch_req;
    logic        restart_pend;
    logic        start_read;
    logic        start_write;
    logic        start_instr;
    logic        instr_active;
    logic        is_instr;
    logic [1:0]  txn_len;
    logic [1:0]  byte_idx;
    logic [1:0]  wr_idx;
    logic        byte_step;
    logic        byte_last;
    logic        write_done;
    logic [31:0] data_buf;

    // Only one of the size fields is active at a time
    assign data_txn_n   = data_req.write_n & data_req.read_n;
    // Bytes minus one: 0, 1 or 3
    assign data_len     = {data_txn_n[1], data_txn_n[1] | data_txn_n[0]};
    assign data_pending = data_txn_n != 2'b11;
    assign fetch_req    = instr_fetch_restart || restart_pend;

    assign is_instr  = instr_active || start_instr;
    assign txn_len   = is_instr ? 2'b01 : data_len;
    assign byte_step = q_data_ready || q_data_req;
    assign byte_last = byte_idx == txn_len;

    always_comb begin
        start_read  = 1'b0;
        start_write = 1'b0;
        start_instr = 1'b0;
        q_stop      = 1'b0;
        if (q_busy || write_done) begin
            if (instr_active) begin
                if (instr_fetch_restart) begin
                    // Abort straight away, the new fetch starts once idle
                    q_stop = 1'b1;
                end else if (q_data_ready && byte_idx == 2'b01 && data_pending) begin
                    q_stop = 1'b1;
                end
            end else if (byte_step && byte_last) begin
                q_stop = 1'b1;
            end
        end else if (data_req.read_n != SIZE_NONE) begin
            start_read = 1'b1;
        end else if (data_req.write_n != SIZE_NONE) begin
            start_write = 1'b1;
        end else if (fetch_req) begin
            start_instr = 1'b1;
        end
    end

    assign q_start_read  = start_read || start_instr;
    assign q_start_write = start_write;
    assign q_addr        = is_instr ? {1'b0, instr_addr, 1'b0} : data_req.addr;

    // The byte after the one being consumed goes out with data_req
    assign wr_idx  = byte_idx + {1'b0, q_data_req};
    assign q_wdata = data_req.wdata[{wr_idx, 3'b000} +: 8];

    // Hold only the second byte of a halfword
    assign q_stall = instr_active && instr_fetch_stall && !instr_ready && byte_idx == 2'b01;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instr_active        <= 1'b0;
            restart_pend        <= 1'b0;
            instr_fetch_started <= 1'b0;
            instr_fetch_stopped <= 1'b0;
            write_done          <= 1'b0;
        end else begin
            if (q_stop) begin
                instr_active <= 1'b0;
            end else if (!q_busy) begin
                instr_active <= start_instr;
            end
            if (start_instr) begin
                restart_pend <= 1'b0;
            end else if (instr_fetch_restart) begin
                restart_pend <= 1'b1;
            end
            instr_fetch_started <= start_instr;
            instr_fetch_stopped <= q_stop && instr_active;
            write_done          <= q_data_req && byte_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            byte_idx <= 2'b00;
        end else if (q_start_read || q_start_write) begin
            byte_idx <= 2'b00;
        end else if (byte_step) begin
            byte_idx <= byte_last ? 2'b00 : byte_idx + 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (q_data_ready) begin
            data_buf[{byte_idx, 3'b000} +: 8] <= q_rdata;
        end
    end

    assign instr_data  = {q_rdata, data_buf[7:0]};
    assign instr_ready = instr_active && q_data_ready && byte_idx == 2'b01;

    assign data_ready = !instr_active && ((q_data_ready && byte_last) || write_done);

    // Last byte arrives live, earlier ones come from the buffer
    always_comb begin
        case (data_len)
            2'b00:   data_from_read = {24'h0, q_rdata};
            2'b01:   data_from_read = {16'h0, q_rdata, data_buf[7:0]};
            default: data_from_read = {q_rdata, data_buf[23:0]};
        endcase
    end

    a_one_kind: assert property (@(posedge clk) disable iff (!rstn)
        !(data_req.read_n != SIZE_NONE && data_req.write_n != SIZE_NONE));

    a_one_ready: assert property (@(posedge clk) disable iff (!rstn)
        !(instr_ready && data_ready));

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
// Memory subsystem shared types
`default_nettype none

package mem_pkg;

    // Access size as encoded by the core, SIZE_NONE means no access
    typedef enum logic [1:0] {
        SIZE_8    = 2'b00,
        SIZE_16   = 2'b01,
        SIZE_32   = 2'b10,
        SIZE_NONE = 2'b11
    } txn_size_e;

    // Data port request, held stable until data_ready
    typedef struct packed {
        logic [24:0] addr;
        txn_size_e   write_n;
        txn_size_e   read_n;
        logic [31:0] wdata;
    } data_req_t;

    // Pins driven toward the flash and the two RAMs
    typedef struct packed {
        logic [3:0] dout;
        logic [3:0] oe;
        logic       sclk;
        logic       flash_sel_n;
        logic       ram_a_sel_n;
        logic       ram_b_sel_n;
    } spi_out_t;

    typedef enum logic [2:0] {
        Q_IDLE,
        Q_CMD,
        Q_ADDR,
        Q_DUMMY,
        Q_DATA
    } qspi_state_e;

    // Quad read and quad write opcodes
    typedef enum logic [7:0] {
        CMD_QREAD  = 8'hEB,
        CMD_QWRITE = 8'h38
    } qspi_cmd_e;

endpackage

`default_nettype wire

//--- rtl/mem_subsys_top.sv
// Memory subsystem top level
`default_nettype none

module mem_subsys_top #(
    parameter int DUMMY_CYCLES = 6
) (
    input  logic               clk,
    input  logic               rstn,

    input  logic [23:1]        instr_addr,
    input  logic               instr_fetch_restart,
    input  logic               instr_fetch_stall,
    output logic               instr_fetch_started,
    output logic               instr_fetch_stopped,
    output logic [15:0]        instr_data,
    output logic               instr_ready,

    input  mem_pkg::data_req_t data_req,
    output logic               data_ready,
    output logic [31:0]        data_from_read,

    input  logic [3:0]         spi_in,
    output mem_pkg::spi_out_t  spi_out
);

    logic [24:0] q_addr;
    logic [7:0]  q_wdata;
    logic        q_start_read;
    logic        q_start_write;
    logic        q_stall;
    logic        q_stop;
    logic [7:0]  q_rdata;
    logic        q_data_req;
    logic        q_data_ready;
    logic        q_busy;

    mem_arbiter i_mem_arbiter (
        .clk                 (clk),
        .rstn                (rstn),
        .instr_addr          (instr_addr),
        .instr_fetch_restart (instr_fetch_restart),
        .instr_fetch_stall   (instr_fetch_stall),
        .instr_fetch_started (instr_fetch_started),
        .instr_fetch_stopped (instr_fetch_stopped),
        .instr_data          (instr_data),
        .instr_ready         (instr_ready),
        .data_req            (data_req),
        .data_ready          (data_ready),
        .data_from_read      (data_from_read),
        .q_addr              (q_addr),
        .q_wdata             (q_wdata),
        .q_start_read        (q_start_read),
        .q_start_write       (q_start_write),
        .q_stall             (q_stall),
        .q_stop              (q_stop),
        .q_rdata             (q_rdata),
        .q_data_req          (q_data_req),
        .q_data_ready        (q_data_ready),
        .q_busy              (q_busy)
    );

    qspi_ctrl #(
        .DUMMY_CYCLES (DUMMY_CYCLES)
    ) i_qspi_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .spi_in      (spi_in),
        .spi_out     (spi_out),
        .addr        (q_addr),
        .wdata       (q_wdata),
        .start_read  (q_start_read),
        .start_write (q_start_write),
        .stall       (q_stall),
        .stop        (q_stop),
        .rdata       (q_rdata),
        .data_req    (q_data_req),
        .data_ready  (q_data_ready),
        .busy        (q_busy)
    );

endmodule

`default_nettype wire

//--- rtl/qspi_ctrl.sv
// Quad-SPI sequencer
`default_nettype none

module qspi_ctrl #(
    parameter int DUMMY_CYCLES = 6
) (
    input  logic              clk,
    input  logic              rstn,

    input  logic [3:0]        spi_in,
    output mem_pkg::spi_out_t spi_out,

    input  logic [24:0]       addr,
    input  logic [7:0]        wdata,
    input  logic              start_read,
    input  logic              start_write,
    input  logic              stall,
    input  logic              stop,

    output logic [7:0]        rdata,
    output logic              data_req,
    output logic              data_ready,
    output logic              busy
);
    import mem_pkg::*;

    localparam int CNT_W = $clog2(DUMMY_CYCLES + 8);

    qspi_state_e      state;
    logic [31:0]      sr;
    logic [CNT_W-1:0] cnt;
    logic             wr_q;
    logic             sclk_q;
    logic [3:0]       oe_q;
    // Active low selects as {ram_b, ram_a, flash}
    logic [2:0]       sel_n;
    logic [2:0]       sel_dec;
    logic [3:0]       rd_hi;
    logic             start;
    logic             hold;
    logic             tick;

    assign start = start_read || start_write;
    assign busy  = state != Q_IDLE;

    // Park the clock low before the second nibble of a data byte
    assign hold = stall && state == Q_DATA && !sclk_q && cnt[0];

    // A full SPI cycle ends on the clk edge where sclk falls
    assign tick = busy && sclk_q;

    // Next write byte is taken from wdata in this cycle
    assign data_req = state == Q_DATA && wr_q && tick && cnt[0];

    // Top two address bits pick the chip
    always_comb begin
        case (addr[24:23])
            2'b10:   sel_dec = 3'b101;
            2'b11:   sel_dec = 3'b011;
            default: sel_dec = 3'b110;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= Q_IDLE;
            sclk_q     <= 1'b0;
            oe_q       <= 4'h0;
            sel_n      <= 3'b111;
            cnt        <= '0;
            wr_q       <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= 1'b0;
            if (stop) begin
                state  <= Q_IDLE;
                sclk_q <= 1'b0;
                oe_q   <= 4'h0;
                sel_n  <= 3'b111;
            end else if (state == Q_IDLE) begin
                if (start) begin
                    state <= Q_CMD;
                    oe_q  <= 4'hf;
                    sel_n <= sel_dec;
                    wr_q  <= start_write;
                    cnt   <= '0;
                end
            end else if (!hold) begin
                sclk_q <= !sclk_q;
                if (sclk_q) begin
                    cnt <= cnt + 1'b1;
                    case (state)
                        Q_CMD: begin
                            if (cnt == CNT_W'(1)) begin
                                state <= Q_ADDR;
                                cnt   <= '0;
                            end
                        end
                        Q_ADDR: begin
                            if (cnt == CNT_W'(5)) begin
                                cnt <= '0;
                                if (wr_q || DUMMY_CYCLES == 0) begin
                                    state <= Q_DATA;
                                end else begin
                                    state <= Q_DUMMY;
                                end
                                // Bus turnaround for reads
                                if (!wr_q) begin
                                    oe_q <= 4'h0;
                                end
                            end
                        end
                        Q_DUMMY: begin
                            if (cnt == CNT_W'(DUMMY_CYCLES - 1)) begin
                                state <= Q_DATA;
                                cnt   <= '0;
                            end
                        end
                        Q_DATA: begin
                            if (!wr_q && cnt[0]) begin
                                data_ready <= 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Shift register and read data
    always_ff @(posedge clk) begin
        if (state == Q_IDLE && start) begin
            sr <= {start_write ? CMD_QWRITE : CMD_QREAD, addr[23:0]};
        end else if (tick) begin
            if ((state == Q_ADDR && cnt == CNT_W'(5) && wr_q) || data_req) begin
                sr[31:24] <= wdata;
            end else begin
                sr <= {sr[27:0], 4'h0};
            end
            // Read nibbles are sampled as sclk falls
            if (state == Q_DATA && !wr_q) begin
                if (!cnt[0]) begin
                    rd_hi <= spi_in;
                end else begin
                    rdata <= {rd_hi, spi_in};
                end
            end
        end
    end

    always_comb begin
        spi_out.dout        = busy ? sr[31:28] : 4'h0;
        spi_out.oe          = oe_q;
        spi_out.sclk        = sclk_q;
        spi_out.flash_sel_n = sel_n[0];
        spi_out.ram_a_sel_n = sel_n[1];
        spi_out.ram_b_sel_n = sel_n[2];
    end

    // Starts only arrive while idle
    a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !busy);

    a_one_select: assert property (@(posedge clk) disable iff (!rstn)
        $countones(~sel_n) <= 1);

endmodule

`default_nettype wire

//--- src.f
rtl/mem_pkg.sv
rtl/qspi_ctrl.sv
rtl/mem_arbiter.sv
rtl/mem_subsys_top.sv
dv/qspi_mem_model.sv
dv/tb_mem_subsys.sv
